/* kb_display_top.f */
logic/board_pkg.sv
logic/ps2_receiver.sv
logic/key_command_unit.sv
logic/sevenseg_display.sv
logic/kb_display_top.sv
verification/tb_clock_gen.sv
verification/kb_display_tb.sv

/* Makefile */
# Verilator build and run for the keyboard display block
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = kb_display_tb
FILELIST  = kb_display_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* verification/kb_display_tb.sv */
/*
 * Directed tests for the keyboard display top. PS/2 frames are driven on
 * the keyboard pins and the result is read back from the multiplexed
 * display and the LEDs. Run it as the top module together with the RTL.
 */
`timescale 1ns/10ps

module kb_display_tb;

   localparam int SCAN_DIV        = 8;
   localparam int RX_TIMEOUT      = 200;
   localparam int NUM_TESTS       = 5;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 20 * 500;
   localparam int SCAN_LIMIT      = SCAN_DIV * board_pkg::DIGITS * 2;

   logic                         sysclk_buf;
   logic                         reset;
   logic                         ps2_clk;
   logic                         ps2_data;
   board_pkg::seg_pattern_t      sevenseg;
   logic [board_pkg::DIGITS-1:0] sevenseg_an;
   logic [7:0]                   led;

   int                           error_count;
   int                           tests_run;
   int                           tests_failed;
   board_pkg::display_value_t    model_value;  // value the display should show

   tb_clock_gen #(.PERIOD_NS(40)) i_tb_clock_gen (.clk(sysclk_buf));

   kb_display_top #(
      .RX_TIMEOUT (RX_TIMEOUT),
      .SCAN_DIV   (SCAN_DIV)
   ) i_kb_display_top (
      .sysclk_buf  (sysclk_buf),
      .reset       (reset),
      .ps2_clk     (ps2_clk),
      .ps2_data    (ps2_data),
      .sevenseg    (sevenseg),
      .sevenseg_an (sevenseg_an),
      .led         (led)
   );

   task automatic compare_seg(input board_pkg::seg_pattern_t got,
                              input board_pkg::seg_pattern_t exp, input string name);
      if (got !== exp)
      begin
         error_count++;
         $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic compare_value(input board_pkg::display_value_t got,
                                input board_pkg::display_value_t exp, input string name);
      if (got !== exp)
      begin
         error_count++;
         $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic compare_code(input board_pkg::scan_code_t got,
                               input board_pkg::scan_code_t exp, input string name);
      if (got !== exp)
      begin
         error_count++;
         $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic compare_anode(input logic [3:0] got, input logic [3:0] exp,
                                input string name);
      if (got !== exp)
      begin
         error_count++;
         $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   // scan code set 2 make codes of the hex keys
   function automatic board_pkg::scan_code_t digit_make_code(input logic [3:0] digit);
      case (digit)
         4'h0: return 8'h45;
         4'h1: return 8'h16;
         4'h2: return 8'h1E;
         4'h3: return 8'h26;
         4'h4: return 8'h25;
         4'h5: return 8'h2E;
         4'h6: return 8'h36;
         4'h7: return 8'h3D;
         4'h8: return 8'h3E;
         4'h9: return 8'h46;
         4'hA: return 8'h1C;
         4'hB: return 8'h32;
         4'hC: return 8'h21;
         4'hD: return 8'h23;
         4'hE: return 8'h24;
         default: return 8'h2B;
      endcase
   endfunction

   function automatic logic [3:0] seg_to_nibble(input board_pkg::seg_pattern_t pat);
      logic [3:0] nib;
      int         n;
      nib = 4'h0;
      for (n = 0; n < 16; n++)
         if (board_pkg::hex_to_seg(4'(n)) == pat)
            nib = 4'(n);
      return nib;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge sysclk_buf);
   endtask

   // start bit, data LSB first, parity, stop; clock idles high
   task automatic send_bits(input board_pkg::scan_code_t code, input bit bad_parity,
                            input int nbits);
      logic [10:0] frame;
      int          i;
      frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
      for (i = 0; i < nbits; i++)
      begin
         ps2_data = frame[i];       // data moves while the clock is high
         wait_cycles(10);
         ps2_clk = 1'b0;
         wait_cycles(20);
         ps2_clk = 1'b1;
         wait_cycles(10);
      end
      ps2_data = 1'b1;
   endtask

   task automatic send_byte(input board_pkg::scan_code_t code, input bit bad_parity);
      send_bits(code, bad_parity, 11);
      wait_cycles(20);              // gap between bytes
   endtask

   task automatic press_key(input board_pkg::scan_code_t code);
      send_byte(code, 1'b0);
      send_byte(board_pkg::SC_BREAK, 1'b0);
      send_byte(code, 1'b0);
   endtask

   task automatic wait_anode_on(input logic [3:0] pattern);
      int waited;
      waited = 0;
      while (sevenseg_an !== pattern && waited < SCAN_LIMIT)
      begin
         @(negedge sysclk_buf);
         waited++;
      end
      if (sevenseg_an !== pattern)
      begin
         error_count++;
         $display("display scan never reached anode pattern 0x%h", pattern);
      end
   endtask

   task automatic wait_anode_off(input logic [3:0] pattern);
      int waited;
      waited = 0;
      while (sevenseg_an === pattern && waited < SCAN_LIMIT)
      begin
         @(negedge sysclk_buf);
         waited++;
      end
      if (sevenseg_an === pattern)
      begin
         error_count++;
         $display("display scan stuck on anode pattern 0x%h", pattern);
      end
   endtask

   // one full scan from digit 0 that checks the anode order on the way
   task automatic read_display(input board_pkg::display_value_t expected);
      board_pkg::seg_pattern_t   pat;
      board_pkg::display_value_t shown;
      logic [3:0]                prev;
      int                        k;
      shown = '0;
      prev  = 4'b1110;
      wait_anode_off(4'b1110);
      wait_anode_on(4'b1110);
      for (k = 0; k < board_pkg::DIGITS; k++)
      begin
         if (k > 0)
         begin
            wait_anode_off(prev);
            compare_anode(sevenseg_an, ~(4'b0001 << k),
                          $sformatf("sevenseg_an step %0d", k));
         end
         pat = sevenseg;
         compare_seg(pat, board_pkg::hex_to_seg(expected[k*4 +: 4]),
                     $sformatf("sevenseg digit %0d", k));
         shown[k*4 +: 4] = seg_to_nibble(pat);
         prev = sevenseg_an;
      end
      compare_value(shown, expected, "displayed value");
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (error_count == errs_before)
         $display("test %0d %s: ok", tests_run, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: fail, %0d errors", tests_run, name,
                  error_count - errs_before);
      end
   endtask

   task automatic test_reset_state();
      int errs_before;
      errs_before = error_count;
      compare_code(led, 8'h00, "led");
      read_display(16'h0000);
      report_test("reset state", errs_before);
   endtask

   task automatic test_hex_entry();
      int         errs_before;
      int         i;
      logic [3:0] digit;
      errs_before = error_count;
      for (i = 0; i < 4; i++)
      begin
         digit = 4'($urandom() % 16);
         press_key(digit_make_code(digit));
         model_value = {model_value[11:0], digit};
         compare_code(led, digit_make_code(digit), "led");
      end
      read_display(model_value);
      report_test("hex entry", errs_before);
   endtask

   task automatic test_backspace_escape();
      int         errs_before;
      int         i;
      logic [3:0] digit;
      errs_before = error_count;
      press_key(board_pkg::SC_BACKSPACE);
      model_value = {4'h0, model_value[15:4]};
      read_display(model_value);
      press_key(board_pkg::SC_ESCAPE);
      model_value = '0;
      read_display(model_value);
      for (i = 0; i < 5; i++)
      begin
         digit = 4'(10 + i);        // A to E so that the E pushes out the A
         press_key(digit_make_code(digit));
         model_value = {model_value[11:0], digit};
         if (i == 3)
            read_display(model_value);
      end
      compare_code(led, digit_make_code(4'hE), "led");
      read_display(model_value);
      report_test("backspace and escape", errs_before);
   endtask

   task automatic test_ignored_codes();
      int errs_before;
      errs_before = error_count;
      send_byte(board_pkg::SC_EXTEND, 1'b0);
      send_byte(digit_make_code(4'h1), 1'b0);
      compare_code(led, digit_make_code(4'h1), "led");
      read_display(model_value);
      send_byte(8'h1D, 1'b0);       // W key, not mapped
      compare_code(led, 8'h1D, "led");
      send_byte(board_pkg::SC_BREAK, 1'b0);
      send_byte(8'h1D, 1'b0);
      read_display(model_value);
      report_test("extended and unmapped codes", errs_before);
   endtask

   task automatic test_bad_frames();
      int errs_before;
      errs_before = error_count;
      send_byte(digit_make_code(4'hF), 1'b1);
      compare_code(led, 8'h1D, "led");
      read_display(model_value);
      send_bits(digit_make_code(4'h0), 1'b0, 5);
      wait_cycles(RX_TIMEOUT + 50);
      send_byte(digit_make_code(4'h7), 1'b0);
      model_value = {model_value[11:0], 4'h7};
      compare_code(led, digit_make_code(4'h7), "led");
      read_display(model_value);
      report_test("bad parity and stalled frame", errs_before);
   endtask

   initial
   begin
      error_count  = 0;
      tests_run    = 0;
      tests_failed = 0;
      model_value  = '0;
      void'($urandom(32'h67e99454));
      reset        = 1'b1;
      ps2_clk      = 1'b1;
      ps2_data     = 1'b1;
      wait_cycles(16);
      reset = 1'b0;
      wait_cycles(4);
      test_reset_state();
      test_hex_entry();
      test_backspace_escape();
      test_ignored_codes();
      test_bad_frames();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
               error_count);
      if (error_count == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // bound on the whole run
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge sysclk_buf);
      $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

/* verification/tb_clock_gen.sv */
/*
 * Free-running testbench clock, low at time zero.
 */
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int PERIOD_NS = 40
) (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

endmodule

/* logic/kb_display_top.sv */
/*
 * Keyboard display bring-up top. PS/2 bytes edit a hex value that is
 * shown on the seven-segment display; the LEDs show the last byte.
 */
`timescale 1ns/10ps

module kb_display_top #(
   parameter int RX_TIMEOUT = 2000,
   parameter int SCAN_DIV   = 1024
) (
   input  logic                         sysclk_buf,
   input  logic                         reset,
   input  logic                         ps2_clk,
   input  logic                         ps2_data,
   output board_pkg::seg_pattern_t      sevenseg,
   output logic [board_pkg::DIGITS-1:0] sevenseg_an,
   output logic [7:0]                   led
);

   board_pkg::scan_code_t     kb_data;
   logic                      kb_ready;
   logic                      frame_error;   // strobe for bring-up probing
   board_pkg::display_value_t value;
   board_pkg::scan_code_t     last_code;

   ps2_receiver #(
      .RX_TIMEOUT (RX_TIMEOUT)
   ) i_ps2_receiver (
      .sysclk_buf  (sysclk_buf),
      .reset       (reset),
      .ps2_clk     (ps2_clk),
      .ps2_data    (ps2_data),
      .kb_data     (kb_data),
      .kb_ready    (kb_ready),
      .frame_error (frame_error)
   );

   key_command_unit i_key_command_unit (
      .sysclk_buf (sysclk_buf),
      .reset      (reset),
      .kb_data    (kb_data),
      .kb_ready   (kb_ready),
      .value      (value),
      .last_code  (last_code)
   );

   sevenseg_display #(
      .SCAN_DIV (SCAN_DIV)
   ) i_sevenseg_display (
      .sysclk_buf  (sysclk_buf),
      .reset       (reset),
      .value       (value),
      .sevenseg    (sevenseg),
      .sevenseg_an (sevenseg_an)
   );

   assign led = last_code;

endmodule

/* logic/sevenseg_display.sv */
/*
 * Multiplexed driver for a four-digit common-anode seven-segment display.
 * Each digit is lit for SCAN_DIV clocks, digit 0 first.
 */
`timescale 1ns/10ps

module sevenseg_display #(
   parameter int SCAN_DIV = 1024
) (
   input  logic                           sysclk_buf,
   input  logic                           reset,
   input  board_pkg::display_value_t      value,
   output board_pkg::seg_pattern_t        sevenseg,
   output logic [board_pkg::DIGITS-1:0]   sevenseg_an
);

   localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
   localparam int IDX_W = $clog2(board_pkg::DIGITS);

   logic [DIV_W-1:0] div_cnt;
   logic [IDX_W-1:0] digit_idx;
   logic [3:0]       digit_val;

   always_ff @(posedge sysclk_buf)
   begin
      if (reset)
      begin
         div_cnt   <= '0;
         digit_idx <= '0;
      end
      else if (div_cnt == DIV_W'(SCAN_DIV - 1))
      begin
         div_cnt   <= '0;
         digit_idx <= digit_idx + 1'b1; // wraps after the last digit
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end

   assign digit_val = value[digit_idx*4 +: 4];

   always_ff @(posedge sysclk_buf)
   begin
      if (reset)
         sevenseg_an <= {{(board_pkg::DIGITS-1){1'b1}}, 1'b0}; // digit 0 lit
      else
         sevenseg_an <= ~(board_pkg::DIGITS'(1) << digit_idx);
   end

   always_ff @(posedge sysclk_buf)
   begin
      sevenseg <= board_pkg::hex_to_seg(digit_val);
   end

   a_one_anode: assert property (@(posedge sysclk_buf) disable iff (reset)
      $onehot(~sevenseg_an));

endmodule

/* logic/key_command_unit.sv */
/*
 * Turns scan-code set 2 bytes into edits of a four-digit hex value.
 * Hex keys shift a digit in from the right, Backspace drops the last
 * digit and Escape clears. Break and extended sequences are skipped.
 */
`timescale 1ns/10ps

module key_command_unit (
   input  logic                      sysclk_buf,
   input  logic                      reset,
   input  board_pkg::scan_code_t     kb_data,
   input  logic                      kb_ready,
   output board_pkg::display_value_t value,
   output board_pkg::scan_code_t     last_code
);

   board_pkg::key_cmd_e cmd;
   logic [3:0]          nibble;
   logic                break_seen;   // F0 received, next byte is a release
   logic                ext_seen;     // E0 received, next byte is an extended key

   // make code decode
   always_comb
   begin
      cmd    = board_pkg::cmd_digit;
      nibble = 4'h0;
      case (kb_data)
         8'h45: nibble = 4'h0;
         8'h16: nibble = 4'h1;
         8'h1E: nibble = 4'h2;
         8'h26: nibble = 4'h3;
         8'h25: nibble = 4'h4;
         8'h2E: nibble = 4'h5;
         8'h36: nibble = 4'h6;
         8'h3D: nibble = 4'h7;
         8'h3E: nibble = 4'h8;
         8'h46: nibble = 4'h9;
         8'h1C: nibble = 4'hA;
         8'h32: nibble = 4'hB;
         8'h21: nibble = 4'hC;
         8'h23: nibble = 4'hD;
         8'h24: nibble = 4'hE;
         8'h2B: nibble = 4'hF;
         board_pkg::SC_BACKSPACE: cmd = board_pkg::cmd_backspace;
         board_pkg::SC_ESCAPE:    cmd = board_pkg::cmd_clear;
         default:                 cmd = board_pkg::cmd_none;
      endcase
   end

   always_ff @(posedge sysclk_buf)
   begin
      if (reset)
      begin
         value      <= '0;
         last_code  <= '0;
         break_seen <= 1'b0;
         ext_seen   <= 1'b0;
      end
      else if (kb_ready)
      begin
         last_code <= kb_data;
         if (kb_data == board_pkg::SC_BREAK)
            break_seen <= 1'b1;
         else if (kb_data == board_pkg::SC_EXTEND)
            ext_seen <= 1'b1;
         else if (break_seen || ext_seen)
         begin
            break_seen <= 1'b0;     // end of a prefixed sequence
            ext_seen   <= 1'b0;
         end
         else
         begin
            case (cmd)
               board_pkg::cmd_digit:     value <= {value[11:0], nibble};
               board_pkg::cmd_backspace: value <= {4'h0, value[15:4]};
               board_pkg::cmd_clear:     value <= '0;
               default:                  value <= value;
            endcase
         end
      end
   end

   // value edits only follow an accepted byte
   a_value_hold: assert property (@(posedge sysclk_buf) disable iff (reset)
      !$past(kb_ready) |-> $stable(value));

endmodule

/* logic/ps2_receiver.sv */
/*
 * PS/2 device-to-host receiver. Frames 11-bit serial words from a keyboard
 * and strobes kb_ready for a good byte or frame_error for a bad one.
 * A stalled partial frame is dropped after RX_TIMEOUT clocks.
 */
`timescale 1ns/10ps

module ps2_receiver #(
   parameter int RX_TIMEOUT = 2000
) (
   input  logic                  sysclk_buf,
   input  logic                  reset,
   input  logic                  ps2_clk,
   input  logic                  ps2_data,
   output board_pkg::scan_code_t kb_data,
   output logic                  kb_ready,
   output logic                  frame_error
);

   localparam int TMO_W = (RX_TIMEOUT > 1) ? $clog2(RX_TIMEOUT) : 1;

   typedef enum logic [1:0] {
      rx_idle,
      rx_shift,
      rx_check
   } rx_state_e;

   rx_state_e        state;
   logic [1:0]       clk_sync;      // two-flop synchronizer, bit 1 is safe
   logic [1:0]       data_sync;
   logic             clk_prev;
   logic             clk_fall;
   logic [10:0]      frame;         // {stop, parity, data[7:0], start}
   logic [3:0]       bit_cnt;
   logic [TMO_W-1:0] idle_cnt;      // clocks since the last falling edge
   logic             frame_ok;

   always_ff @(posedge sysclk_buf)
   begin
      if (reset)
      begin
         clk_sync  <= 2'b11;        // bus idles high
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
      end
      else
      begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_prev  <= clk_sync[1];
      end
   end

   assign clk_fall = clk_prev & ~clk_sync[1];

   // bits arrive LSB first, so shift in from the top
   always_ff @(posedge sysclk_buf)
   begin
      if (clk_fall && (state != rx_check))
         frame <= {data_sync[1], frame[10:1]};
   end

   always_ff @(posedge sysclk_buf)
   begin
      if (reset)
      begin
         state    <= rx_idle;
         bit_cnt  <= '0;
         idle_cnt <= '0;
      end
      else
      begin
         case (state)
            rx_idle:
            begin
               idle_cnt <= '0;
               if (clk_fall)
               begin
                  state   <= rx_shift;
                  bit_cnt <= 4'd1;  // start bit taken
               end
            end
            rx_shift:
            begin
               if (clk_fall)
               begin
                  bit_cnt  <= bit_cnt + 4'd1;
                  idle_cnt <= '0;
                  if (bit_cnt == 4'd10)
                     state <= rx_check;
               end
               else if (idle_cnt == TMO_W'(RX_TIMEOUT - 1))
               begin
                  state   <= rx_idle; // keyboard went quiet mid-frame
                  bit_cnt <= '0;
               end
               else
                  idle_cnt <= idle_cnt + 1'b1;
            end
            default:
            begin
               state   <= rx_idle;
               bit_cnt <= '0;
            end
         endcase
      end
   end

   // start low, stop high, odd parity over data and parity bit
   assign frame_ok    = ~frame[0] & frame[10] & (^frame[9:1]);
   assign kb_data     = frame[8:1];
   assign kb_ready    = (state == rx_check) & frame_ok;
   assign frame_error = (state == rx_check) & ~frame_ok;

   a_strobe_excl: assert property (@(posedge sysclk_buf) disable iff (reset)
      !(kb_ready && frame_error));

   a_bit_cnt_max: assert property (@(posedge sysclk_buf) disable iff (reset)
      bit_cnt <= 4'd11);

endmodule

/* logic/board_pkg.sv */
/*
 * Shared types and constants for the keyboard display block.
 * Modules refer to these by scoped names; the testbench uses
 * hex_to_seg and the scan-code constants to build expected results.
 */
package board_pkg;

   localparam int DIGITS = 4;                   // number of display digits

   typedef logic [7:0] scan_code_t;             // one PS/2 data byte
   typedef logic [4*DIGITS-1:0] display_value_t; // four hex digits
   typedef logic [7:0] seg_pattern_t;           // {dp, g..a}, active low

   typedef enum logic [1:0] {
      cmd_none,
      cmd_digit,
      cmd_backspace,
      cmd_clear
   } key_cmd_e;

   // scan code set 2 prefixes and edit keys
   localparam scan_code_t SC_BREAK     = 8'hF0;
   localparam scan_code_t SC_EXTEND    = 8'hE0;
   localparam scan_code_t SC_BACKSPACE = 8'h66;
   localparam scan_code_t SC_ESCAPE    = 8'h76;

   // hex font, segment a in bit 0, decimal point (bit 7) off
   function automatic seg_pattern_t hex_to_seg(input logic [3:0] nibble);
      case (nibble)
         4'h0: return 8'hC0;
         4'h1: return 8'hF9;
         4'h2: return 8'hA4;
         4'h3: return 8'hB0;
         4'h4: return 8'h99;
         4'h5: return 8'h92;
         4'h6: return 8'h82;
         4'h7: return 8'hF8;
         4'h8: return 8'h80;
         4'h9: return 8'h90;
         4'hA: return 8'h88;
         4'hB: return 8'h83;         // lower case b
         4'hC: return 8'hC6;
         4'hD: return 8'hA1;         // lower case d
         4'hE: return 8'h86;
         default: return 8'h8E;
      endcase
   endfunction

endpackage
